// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  rv32i_pipe_pkg::fd_payload_t fd_i,
    input  logic                        fd_valid_i,
    input  rv32i_pipe_pkg::mw_payload_t mw_i,
    input  logic                        mw_valid_i,
    output rv32i_pipe_pkg::de_payload_t de_o,
    output logic                        de_valid_o,
    output rv32i_pipe_pkg::rv32i_reg    rs1_o,
    output rv32i_pipe_pkg::rv32i_reg    rs2_o,
    output logic                        commit_valid_o,
    output rv32i_pipe_pkg::commit_t     commit_o
);
    import rv32i_pipe_pkg::*;

    rv32i_word   rf [32];
    rv32i_word   instr;
    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    rv32i_word   i_imm;
    rv32i_word   s_imm;
    rv32i_word   b_imm;
    rv32i_word   u_imm;
    control_word cw;
    rv32i_word   imm;
    logic        supported;
    logic        rf_we;

    assign instr  = fd_i.instr;
    assign opcode = rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};
    assign s_imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm  = {instr[31:12], 12'h000};

    always_comb begin
        cw        = '0;  // add, alu writeback, no side effects
        imm       = '0;
        supported = 1'b1;
        cw.rd     = instr[11:7];
        case (opcode)
            op_lui: begin
                cw.alu_op    = alu_pass_b;
                cw.use_imm   = 1'b1;
                cw.reg_write = 1'b1;
                imm          = u_imm;
            end
            op_imm, op_reg: begin
                cw.use_imm   = (opcode == op_imm);
                cw.reg_write = 1'b1;
                cw.rs1       = instr[19:15];
                cw.rs2       = (opcode == op_reg) ? instr[24:20] : '0;
                imm          = i_imm;
                case (funct3)
                    3'b000: cw.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b100: cw.alu_op = alu_xor;
                    3'b110: cw.alu_op = alu_or;
                    3'b111: cw.alu_op = alu_and;
                    default: supported = 1'b0;
                endcase
                if (opcode == op_reg && funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'b000)) begin
                    supported = 1'b0;
                end
            end
            op_load: begin
                cw.use_imm   = 1'b1;
                cw.mem_read  = 1'b1;
                cw.reg_write = 1'b1;
                cw.wb_sel    = wb_mem;
                cw.rs1       = instr[19:15];
                imm          = i_imm;
                supported    = (funct3 == 3'b010);  // lw only
            end
            op_store: begin
                cw.use_imm   = 1'b1;
                cw.mem_write = 1'b1;
                cw.rs1       = instr[19:15];
                cw.rs2       = instr[24:20];
                imm          = s_imm;
                supported    = (funct3 == 3'b010);  // sw only
            end
            op_br: begin
                cw.branch    = 1'b1;
                cw.branch_ne = funct3[0];
                cw.rs1       = instr[19:15];
                cw.rs2       = instr[24:20];
                imm          = b_imm;
                supported    = (funct3[2:1] == 2'b00);  // beq, bne
            end
            default: supported = 1'b0;
        endcase
    end

    // writeback port, x0 never written
    assign rf_we = mw_valid_i & mw_i.reg_write & (mw_i.rd != '0);

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[mw_i.rd] <= mw_i.wdata;
        end
    end

    always_comb begin
        de_o.cw  = cw;
        de_o.pc  = fd_i.pc;
        de_o.imm = imm;
        if (cw.rs1 == '0) de_o.rs1_data = '0;
        else if (rf_we && mw_i.rd == cw.rs1) de_o.rs1_data = mw_i.wdata;  // write-through
        else de_o.rs1_data = rf[cw.rs1];
        if (cw.rs2 == '0) de_o.rs2_data = '0;
        else if (rf_we && mw_i.rd == cw.rs2) de_o.rs2_data = mw_i.wdata;
        else de_o.rs2_data = rf[cw.rs2];
    end

    assign de_valid_o = fd_valid_i & supported;
    assign rs1_o      = de_valid_o ? cw.rs1 : '0;  // hazard check sees only live sources
    assign rs2_o      = de_valid_o ? cw.rs2 : '0;

    assign commit_valid_o = mw_valid_i;
    assign commit_o.pc    = mw_i.pc;
    assign commit_o.rd    = mw_i.reg_write ? mw_i.rd : '0;
    assign commit_o.wdata = rf_we ? mw_i.wdata : '0;

endmodule : decode_stage

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  rv32i_pipe_pkg::de_payload_t de_i,
    input  rv32i_pipe_pkg::em_payload_t em_i,
    input  logic                        em_valid_i,
    input  rv32i_pipe_pkg::mw_payload_t mw_i,
    input  logic                        mw_valid_i,
    input  logic                        de_valid_i,
    output rv32i_pipe_pkg::em_payload_t em_o,
    output logic                        branch_taken_o,
    output rv32i_pipe_pkg::rv32i_word   target_o
);
    import rv32i_pipe_pkg::*;

    rv32i_word op_a;
    rv32i_word rs2_fwd;
    rv32i_word op_b;
    rv32i_word alu_out;

    // em result first, then mw, else the value read in decode
    function automatic rv32i_word fwd(rv32i_reg rs, rv32i_word rf_val);
        if (rs != '0 && em_valid_i && em_i.cw.reg_write && em_i.cw.wb_sel == wb_alu &&
            em_i.cw.rd == rs) begin
            return em_i.alu_out;
        end
        if (rs != '0 && mw_valid_i && mw_i.reg_write && mw_i.rd == rs) begin
            return mw_i.wdata;
        end
        return rf_val;
    endfunction

    assign op_a    = fwd(de_i.cw.rs1, de_i.rs1_data);
    assign rs2_fwd = fwd(de_i.cw.rs2, de_i.rs2_data);
    assign op_b    = de_i.cw.use_imm ? de_i.imm : rs2_fwd;

    always_comb begin
        case (de_i.cw.alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign branch_taken_o = de_valid_i & de_i.cw.branch &
                            ((op_a == rs2_fwd) ^ de_i.cw.branch_ne);
    assign target_o       = de_i.pc + de_i.imm;

    assign em_o.cw       = de_i.cw;
    assign em_o.pc       = de_i.pc;
    assign em_o.alu_out  = alu_out;
    assign em_o.rs2_data = rs2_fwd;  // store data

endmodule : exe_stage

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h0
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        pc_load_i,
    input  rv32i_pipe_pkg::pcmux_sel_e  pcmux_sel_i,
    input  rv32i_pipe_pkg::rv32i_word   target_i,
    output logic                        imem_read_o,
    output rv32i_pipe_pkg::rv32i_word   imem_addr_o,
    input  rv32i_pipe_pkg::rv32i_word   imem_rdata_i,
    input  logic                        imem_resp_i,
    output logic                        fetch_rdy_o,
    output rv32i_pipe_pkg::fd_payload_t fd_o,
    output logic                        valid_o
);
    import rv32i_pipe_pkg::*;

    rv32i_word pc_q;
    rv32i_word tgt_q;    // redirect target parked while a fetch is in flight
    rv32i_word instr_q;
    logic      req_q;
    logic      buf_q;    // instruction latched, waiting for the fd register
    logic      drop_q;   // next resp belongs to a squashed path
    logic      waiting;
    logic      resp_ok;
    logic      redirect;
    logic      advance;

    assign waiting     = req_q & ~imem_resp_i;
    assign resp_ok     = req_q & imem_resp_i & ~drop_q;
    assign redirect    = pc_load_i & (pcmux_sel_i == pcmux_target);
    assign advance     = pc_load_i & (redirect | valid_o);
    assign valid_o     = buf_q | resp_ok;
    assign fetch_rdy_o = ~waiting;
    assign imem_read_o = req_q;
    assign imem_addr_o = pc_q;  // only moves when no request is waiting
    assign fd_o.pc     = pc_q;
    assign fd_o.instr  = buf_q ? instr_q : imem_rdata_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q   <= RESET_PC;
            req_q  <= 1'b0;
            buf_q  <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            if (req_q && imem_resp_i) begin
                req_q <= 1'b0;  // one idle cycle after every resp
            end else if (!req_q && (!buf_q || advance)) begin
                req_q <= 1'b1;
            end

            if (redirect && !waiting) begin
                pc_q <= target_i;
            end else if (advance && !waiting) begin
                pc_q <= pc_q + 32'd4;
            end else if (req_q && imem_resp_i && drop_q) begin
                pc_q <= tgt_q;
            end

            if (redirect && waiting) begin
                drop_q <= 1'b1;
            end else if (req_q && imem_resp_i) begin
                drop_q <= 1'b0;
            end

            if (advance) begin
                buf_q <= 1'b0;
            end else if (resp_ok) begin
                buf_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect && waiting) begin
            tgt_q <= target_i;
        end
        if (resp_ok) begin
            instr_q <= imem_rdata_i;
        end
    end

endmodule : fetch_stage

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  rv32i_pipe_pkg::em_payload_t em_i,
    input  logic                        em_valid_i,
    output logic                        dmem_read_o,
    output logic                        dmem_write_o,
    output rv32i_pipe_pkg::rv32i_word   dmem_addr_o,
    output rv32i_pipe_pkg::rv32i_word   dmem_wdata_o,
    input  rv32i_pipe_pkg::rv32i_word   dmem_rdata_i,
    input  logic                        dmem_resp_i,
    output logic                        mem_rdy_o,
    output rv32i_pipe_pkg::mw_payload_t mw_o
);
    import rv32i_pipe_pkg::*;

    logic      access;
    logic      done;
    logic      done_q;
    rv32i_word done_pc_q;  // tags the finished access
    rv32i_word rdata_q;

    assign access = em_valid_i & (em_i.cw.mem_read | em_i.cw.mem_write);
    // back-to-back accesses always differ in pc
    assign done   = done_q & (done_pc_q == em_i.pc);

    assign dmem_read_o  = access & em_i.cw.mem_read & ~done;
    assign dmem_write_o = access & em_i.cw.mem_write & ~done;
    assign dmem_addr_o  = em_i.alu_out;
    assign dmem_wdata_o = em_i.rs2_data;
    assign mem_rdy_o    = ~access | done | dmem_resp_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (dmem_resp_i) begin
            done_q <= 1'b1;
        end else if (!access) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_resp_i) begin
            done_pc_q <= em_i.pc;
            rdata_q   <= dmem_rdata_i;  // kept while the pipe is held
        end
    end

    assign mw_o.reg_write = em_i.cw.reg_write;
    assign mw_o.rd        = em_i.cw.rd;
    assign mw_o.pc        = em_i.pc;
    assign mw_o.wdata     = (em_i.cw.wb_sel == wb_alu) ? em_i.alu_out :
                            done ? rdata_q : dmem_rdata_i;

endmodule : mem_stage

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                        fetch_rdy_i,
    input  logic                        mem_rdy_i,
    input  logic                        branch_taken_i,
    input  rv32i_pipe_pkg::rv32i_reg    rs1_i,
    input  rv32i_pipe_pkg::rv32i_reg    rs2_i,
    input  rv32i_pipe_pkg::control_word de_cw_i,
    input  logic                        de_valid_i,
    output logic                        pc_load_o,
    output logic                        fd_load_o,
    output logic                        de_load_o,
    output logic                        em_load_o,
    output logic                        mw_load_o,
    output logic                        fd_flush_o,
    output logic                        de_flush_o
);

    logic stall;
    logic load_use;

    // a taken branch does not wait on fetch, its fetch is squashed anyway
    assign stall    = ~mem_rdy_i | (~fetch_rdy_i & ~branch_taken_i);
    assign load_use = de_valid_i & de_cw_i.mem_read & (de_cw_i.rd != '0) &
                      ((de_cw_i.rd == rs1_i) | (de_cw_i.rd == rs2_i));

    assign pc_load_o  = ~stall & (~load_use | branch_taken_i);
    assign fd_load_o  = ~stall & (~load_use | branch_taken_i);  // hold on load-use
    assign de_load_o  = ~stall;
    assign em_load_o  = ~stall;
    assign mw_load_o  = ~stall;
    assign fd_flush_o = ~stall & branch_taken_i;
    assign de_flush_o = ~stall & (branch_taken_i | load_use);   // bubble or squash

endmodule : pipe_ctrl

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic load_i,
    input  logic flush_i,
    input  logic valid_i,
    input  T     d_i,
    output logic valid_o,
    output T     q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;  // flush beats load
        end else if (load_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            q_o <= d_i;
        end
    end

endmodule : pipe_reg

// ==== rv32i_pipe.f ====
rv32i_pipe_pkg.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
exe_stage.sv
mem_stage.sv
pipe_ctrl.sv
rv32i_pipe.sv
rv32i_pipe_chk.sv
rv32i_pipe_tb.sv

// ==== rv32i_pipe.sv ====
`timescale 1ns/1ps

module rv32i_pipe #(
    parameter rv32i_pipe_pkg::rv32i_word RESET_PC = 32'h0
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    output logic                      imem_read_o,
    output rv32i_pipe_pkg::rv32i_word imem_addr_o,
    input  rv32i_pipe_pkg::rv32i_word imem_rdata_i,
    input  logic                      imem_resp_i,
    output logic                      dmem_read_o,
    output logic                      dmem_write_o,
    output rv32i_pipe_pkg::rv32i_word dmem_addr_o,
    output rv32i_pipe_pkg::rv32i_word dmem_wdata_o,
    input  rv32i_pipe_pkg::rv32i_word dmem_rdata_i,
    input  logic                      dmem_resp_i,
    output logic                      commit_valid_o,
    output rv32i_pipe_pkg::commit_t   commit_o
);
    import rv32i_pipe_pkg::*;

    fd_payload_t fd_d, fd_q;
    de_payload_t de_d, de_q;
    em_payload_t em_d, em_q;
    mw_payload_t mw_d, mw_q;
    logic        fetch_valid, fd_valid, de_d_valid, de_valid, em_valid, mw_valid;
    logic        fetch_rdy, mem_rdy, branch_taken;
    rv32i_word   target;
    pcmux_sel_e  pcmux_sel;
    rv32i_reg    rs1, rs2;
    logic        pc_load, fd_load, de_load, em_load, mw_load, fd_flush, de_flush;
    logic        mw_fresh;  // mw holds a new instruction this cycle

    assign pcmux_sel = branch_taken ? pcmux_target : pcmux_plus4;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mw_fresh <= 1'b0;
        end else begin
            mw_fresh <= mw_load;  // a held writeback commits once
        end
    end

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .pc_load_i(pc_load), .pcmux_sel_i(pcmux_sel), .target_i(target),
        .imem_read_o(imem_read_o), .imem_addr_o(imem_addr_o),
        .imem_rdata_i(imem_rdata_i), .imem_resp_i(imem_resp_i),
        .fetch_rdy_o(fetch_rdy), .fd_o(fd_d), .valid_o(fetch_valid)
    );

    pipe_reg #(.T(fd_payload_t)) fd_reg_inst (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(fd_load), .flush_i(fd_flush),
        .valid_i(fetch_valid), .d_i(fd_d), .valid_o(fd_valid), .q_o(fd_q)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .fd_i(fd_q), .fd_valid_i(fd_valid),
        .mw_i(mw_q), .mw_valid_i(mw_valid & mw_fresh),
        .de_o(de_d), .de_valid_o(de_d_valid), .rs1_o(rs1), .rs2_o(rs2),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o)
    );

    pipe_reg #(.T(de_payload_t)) de_reg_inst (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(de_load), .flush_i(de_flush),
        .valid_i(de_d_valid), .d_i(de_d), .valid_o(de_valid), .q_o(de_q)
    );

    exe_stage exe_stage_inst (
        .de_i(de_q), .de_valid_i(de_valid),
        .em_i(em_q), .em_valid_i(em_valid),
        .mw_i(mw_q), .mw_valid_i(mw_valid),  // full valid, forwarding spans the hold
        .em_o(em_d), .branch_taken_o(branch_taken), .target_o(target)
    );

    pipe_reg #(.T(em_payload_t)) em_reg_inst (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(em_load), .flush_i(1'b0),
        .valid_i(de_valid), .d_i(em_d), .valid_o(em_valid), .q_o(em_q)
    );

    mem_stage mem_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i), .em_i(em_q), .em_valid_i(em_valid),
        .dmem_read_o(dmem_read_o), .dmem_write_o(dmem_write_o),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_rdata_i(dmem_rdata_i), .dmem_resp_i(dmem_resp_i),
        .mem_rdy_o(mem_rdy), .mw_o(mw_d)
    );

    pipe_reg #(.T(mw_payload_t)) mw_reg_inst (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(mw_load), .flush_i(1'b0),
        .valid_i(em_valid), .d_i(mw_d), .valid_o(mw_valid), .q_o(mw_q)
    );

    pipe_ctrl pipe_ctrl_inst (
        .fetch_rdy_i(fetch_rdy), .mem_rdy_i(mem_rdy), .branch_taken_i(branch_taken),
        .rs1_i(rs1), .rs2_i(rs2), .de_cw_i(de_q.cw), .de_valid_i(de_valid),
        .pc_load_o(pc_load), .fd_load_o(fd_load), .de_load_o(de_load),
        .em_load_o(em_load), .mw_load_o(mw_load),
        .fd_flush_o(fd_flush), .de_flush_o(de_flush)
    );

endmodule : rv32i_pipe

// ==== rv32i_pipe_chk.sv ====
`timescale 1ns/1ps

module rv32i_pipe_chk (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      imem_read_i,
    input rv32i_pipe_pkg::rv32i_word imem_addr_i,
    input logic                      imem_resp_i,
    input logic                      dmem_read_i,
    input logic                      dmem_write_i,
    input rv32i_pipe_pkg::rv32i_word dmem_addr_i,
    input rv32i_pipe_pkg::rv32i_word dmem_wdata_i,
    input logic                      dmem_resp_i,
    input logic                      commit_valid_i
);

    int unsigned reset_errs = 0;
    int unsigned hs_errs = 0;
    logic        dreq;

    assign dreq = dmem_read_i | dmem_write_i;

    // quiet in reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        (!rst_n_i || $rose(rst_n_i)) |-> !(imem_read_i || dreq || commit_valid_i))
        else begin
            $error("memory strobe or commit active around reset");
            reset_errs++;
        end

    imem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_read_i && !imem_resp_i |=> imem_read_i && $stable(imem_addr_i))
        else begin
            $error("imem request moved before resp");
            hs_errs++;
        end

    imem_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_resp_i |=> !imem_read_i)  // one idle cycle after resp
        else begin
            $error("imem request still up after resp");
            hs_errs++;
        end

    dmem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq && !dmem_resp_i |=> $stable(dmem_read_i) && $stable(dmem_write_i) &&
                                 $stable(dmem_addr_i) && $stable(dmem_wdata_i))
        else begin
            $error("dmem request moved before resp");
            hs_errs++;
        end

    // answered access must not repeat, a different access may follow
    dmem_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_resp_i |=> !dreq || !($stable(dmem_read_i) && $stable(dmem_write_i) &&
                                   $stable(dmem_addr_i) && $stable(dmem_wdata_i)))
        else begin
            $error("dmem request repeated after resp");
            hs_errs++;
        end

endmodule : rv32i_pipe_chk

bind rv32i_pipe rv32i_pipe_chk rv32i_pipe_chk_inst (
    .clk(clk), .rst_n_i(rst_n_i),
    .imem_read_i(imem_read_o), .imem_addr_i(imem_addr_o), .imem_resp_i(imem_resp_i),
    .dmem_read_i(dmem_read_o), .dmem_write_i(dmem_write_o), .dmem_addr_i(dmem_addr_o),
    .dmem_wdata_i(dmem_wdata_o), .dmem_resp_i(dmem_resp_i),
    .commit_valid_i(commit_valid_o)
);

// ==== rv32i_pipe_pkg.sv ====
package rv32i_pipe_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b  // LUI
    } alu_op_e;

    typedef enum logic {wb_alu, wb_mem} wb_sel_e;

    typedef enum logic {pcmux_plus4, pcmux_target} pcmux_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;    // operand b from imm
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     branch_ne;  // bne when set, beq otherwise
        logic     reg_write;
        wb_sel_e  wb_sel;
        rv32i_reg rd;
        rv32i_reg rs1;
        rv32i_reg rs2;
    } control_word;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
    } fd_payload_t;

    typedef struct packed {
        control_word cw;
        rv32i_word   pc;
        rv32i_word   rs1_data;
        rv32i_word   rs2_data;
        rv32i_word   imm;
    } de_payload_t;

    typedef struct packed {
        control_word cw;
        rv32i_word   pc;        // carried for the commit port
        rv32i_word   alu_out;
        rv32i_word   rs2_data;
    } em_payload_t;

    typedef struct packed {
        logic      reg_write;
        rv32i_reg  rd;
        rv32i_word wdata;
        rv32i_word pc;
    } mw_payload_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_reg  rd;
        rv32i_word wdata;
    } commit_t;

endpackage : rv32i_pipe_pkg

// ==== rv32i_pipe_tb.sv ====
`timescale 1ns/1ps

module rv32i_pipe_tb;
    import rv32i_pipe_pkg::*;

    localparam int clk_period      = 40;
    localparam int max_lat         = 3;
    localparam int prog_len        = 21;  // words 0x00 to 0x50
    localparam int watchdog_cycles = prog_len * 4 * max_lat + 100;
    localparam logic [6:0] opc_imm  = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;

    logic      clk;
    logic      rst_n_i;
    logic      imem_read_o;
    rv32i_word imem_addr_o;
    rv32i_word imem_rdata_i;
    logic      imem_resp_i;
    logic      dmem_read_o;
    logic      dmem_write_o;
    rv32i_word dmem_addr_o;
    rv32i_word dmem_wdata_o;
    rv32i_word dmem_rdata_i;
    logic      dmem_resp_i;
    logic      commit_valid_o;
    commit_t   commit_o;

    rv32i_word imem [64];
    rv32i_word dmem [64];
    integer    seed;
    int        i_cnt;
    int        d_cnt;
    commit_t   exp_q [$];
    int        exp_tag [$];
    int        exp_idx;
    bit        seen_store;
    string     test_name [1:5];
    int        test_errs [1:5];
    int        test_total [1:5];
    int        test_seen [1:5];

    rv32i_pipe #(.RESET_PC(32'h0)) rv32i_pipe_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic rv32i_word enc_u(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic rv32i_word enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_word enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_word enc_s(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_word enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function int draw_latency();
        return 1 + ($unsigned($random(seed)) % max_lat);
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = enc_i(opc_imm, 3'b000, 5'd0, 5'd0, i * 4);  // nop tagged with address
            dmem[i] = 32'hd000_0000 | (i * 4);
        end
        imem[0]  = enc_u(5'd1, 20'h12345);
        imem[1]  = enc_i(opc_imm, 3'b000, 5'd2, 5'd1, 32'h678);
        imem[2]  = enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1);   // add
        imem[3]  = enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd2);   // sub
        imem[4]  = enc_r(7'h00, 3'b111, 5'd5, 5'd4, 5'd2);   // and
        imem[5]  = enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);   // or
        imem[6]  = enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd1);   // xor
        imem[7]  = enc_i(opc_imm, 3'b000, 5'd8, 5'd0, 32'h100);
        imem[8]  = enc_s(5'd7, 5'd8, 32'h0);                 // sw x7, 0(x8)
        imem[9]  = enc_i(opc_load, 3'b010, 5'd9, 5'd8, 32'h0);
        imem[10] = enc_r(7'h00, 3'b000, 5'd10, 5'd9, 5'd7);  // load-use
        imem[11] = enc_b(3'b000, 5'd10, 5'd10, 32'd12);      // beq taken to 0x38
        imem[12] = enc_i(opc_imm, 3'b000, 5'd11, 5'd0, 32'd1);
        imem[13] = enc_i(opc_imm, 3'b000, 5'd12, 5'd0, 32'd2);
        imem[14] = enc_b(3'b001, 5'd9, 5'd7, 32'd8);         // bne falls through
        imem[15] = enc_i(opc_imm, 3'b000, 5'd13, 5'd0, 32'd5);
        imem[16] = enc_b(3'b001, 5'd13, 5'd0, 32'd12);       // bne taken to 0x4c
        imem[17] = enc_i(opc_imm, 3'b000, 5'd14, 5'd0, 32'hffff_ffff);
        imem[18] = enc_i(opc_imm, 3'b000, 5'd15, 5'd0, 32'hffff_ffff);
        imem[19] = enc_i(opc_imm, 3'b000, 5'd16, 5'd13, 32'd3);
        imem[20] = enc_b(3'b000, 5'd0, 5'd0, 32'd0);         // spin here
    endtask

    task automatic add_commit(rv32i_word pc, rv32i_reg rd, rv32i_word wdata, int tag);
        exp_q.push_back('{pc: pc, rd: rd, wdata: wdata});
        exp_tag.push_back(tag);
        test_total[tag]++;
    endtask

    task automatic load_expected();
        add_commit(32'h00, 5'd1, 32'h1234_5000, 2);
        add_commit(32'h04, 5'd2, 32'h1234_5678, 2);
        add_commit(32'h08, 5'd3, 32'h2468_a678, 2);
        add_commit(32'h0c, 5'd4, 32'h1234_5000, 2);
        add_commit(32'h10, 5'd5, 32'h1234_5000, 2);
        add_commit(32'h14, 5'd6, 32'h1234_5678, 2);
        add_commit(32'h18, 5'd7, 32'h0000_0678, 2);
        add_commit(32'h1c, 5'd8, 32'h0000_0100, 2);
        add_commit(32'h20, 5'd0, 32'h0, 3);
        add_commit(32'h24, 5'd9, 32'h0000_0678, 3);
        add_commit(32'h28, 5'd10, 32'h0000_0cf0, 3);
        add_commit(32'h2c, 5'd0, 32'h0, 4);
        add_commit(32'h38, 5'd0, 32'h0, 4);
        add_commit(32'h3c, 5'd13, 32'h5, 4);
        add_commit(32'h40, 5'd0, 32'h0, 4);
        add_commit(32'h4c, 5'd16, 32'h8, 4);
        add_commit(32'h50, 5'd0, 32'h0, 4);
        add_commit(32'h50, 5'd0, 32'h0, 4);
    endtask

    task automatic show_commit_mismatch(commit_t exp);
        if (commit_o.pc != exp.pc)
            $display("[FAIL] commit_o.pc exp 0x%08h got 0x%08h", exp.pc, commit_o.pc);
        if (commit_o.rd != exp.rd)
            $display("[FAIL] commit_o.rd exp 0x%02h got 0x%02h", exp.rd, commit_o.rd);
        if (commit_o.wdata != exp.wdata)
            $display("[FAIL] commit_o.wdata exp 0x%08h got 0x%08h", exp.wdata, commit_o.wdata);
    endtask

    // both memories in one block so the random draws keep a fixed order
    always @(posedge clk) begin
        if (!rst_n_i) begin
            imem_resp_i <= 1'b0;
            dmem_resp_i <= 1'b0;
            i_cnt = 0;
            d_cnt = 0;
        end else begin
            if (imem_resp_i) begin
                imem_resp_i <= 1'b0;
            end else if (imem_read_o) begin
                if (i_cnt == 0) i_cnt = draw_latency();
                i_cnt = i_cnt - 1;
                if (i_cnt == 0) begin
                    imem_resp_i  <= 1'b1;
                    imem_rdata_i <= imem[imem_addr_o[7:2]];
                end
            end
            if (dmem_resp_i) begin
                dmem_resp_i <= 1'b0;
            end else if (dmem_read_o || dmem_write_o) begin
                if (d_cnt == 0) d_cnt = draw_latency();
                d_cnt = d_cnt - 1;
                if (d_cnt == 0) begin
                    dmem_resp_i  <= 1'b1;
                    dmem_rdata_i <= dmem[dmem_addr_o[7:2]];
                    if (dmem_write_o) dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
                end
            end
        end
    end

    // mid-cycle sampling, outputs settled
    always @(negedge clk) begin
        if (rst_n_i && commit_valid_o && exp_idx < exp_q.size()) begin
            assert (commit_o == exp_q[exp_idx]) else begin
                show_commit_mismatch(exp_q[exp_idx]);
                test_errs[exp_tag[exp_idx]]++;
            end
            test_seen[exp_tag[exp_idx]]++;
            exp_idx++;
        end
        if (rst_n_i && dmem_write_o) begin
            seen_store = 1'b1;
            assert (dmem_addr_o == 32'h100 && dmem_wdata_o == 32'h678) else begin
                $display("[FAIL] dmem_addr_o exp 0x00000100 got 0x%08h", dmem_addr_o);
                $display("[FAIL] dmem_wdata_o exp 0x00000678 got 0x%08h", dmem_wdata_o);
                test_errs[3]++;
            end
        end
    end

    task automatic print_report(bit timed_out);
        int failed;
        int errs;
        failed = 0;
        errs = 0;
        test_errs[1] += rv32i_pipe_inst.rv32i_pipe_chk_inst.reset_errs;
        test_errs[5] += rv32i_pipe_inst.rv32i_pipe_chk_inst.hs_errs;
        assert (seen_store) else begin
            $display("the store never reached the data port");
            test_errs[3]++;
        end
        if (timed_out) $display("watchdog stopped the run after %0d cycles", watchdog_cycles);
        for (int t = 1; t <= 5; t++) begin
            assert (test_seen[t] == test_total[t]) else begin
                $display("%s stopped after %0d of %0d commits", test_name[t], test_seen[t],
                         test_total[t]);
                test_errs[t]++;
            end
            $display("test %0d (%s): %0d errors", t, test_name[t], test_errs[t]);
            errs += test_errs[t];
            if (test_errs[t] != 0) failed++;
        end
        $display("tests: 5, failed: %0d, errors: %0d", failed, errs);
        if (failed == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        imem_rdata_i = '0;
        imem_resp_i = 1'b0;
        dmem_rdata_i = '0;
        dmem_resp_i = 1'b0;
        seed = 75;
        exp_idx = 0;
        seen_store = 1'b0;
        test_name = '{"reset", "arithmetic forwarding", "store and load", "branches",
                      "handshake"};
        for (int t = 1; t <= 5; t++) begin
            test_errs[t] = 0;
            test_total[t] = 0;
            test_seen[t] = 0;
        end
        load_program();
        load_expected();
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        wait (exp_idx == exp_q.size());
        repeat (2) @(posedge clk);
        print_report(1'b0);
    end

    initial begin
        #(watchdog_cycles * clk_period);
        print_report(1'b1);
    end

endmodule : rv32i_pipe_tb
